// ==== cnn_top.f ====
+incdir+.
cnn_pkg.sv
row_deserializer.sv
window_buffer.sv
kernel_mac.sv
conv_row_control.sv
max_pool_row.sv
row_serializer.sv
cnn_top.sv
cnn_checker.sv
tb_cnn_top.sv

// ==== cnn_cases.txt ====
# name code(0 constant, 1 ramp, 2 checker) a b stall_mode expected_sum expected_first
# ramp pixel is (a*col + b*row) mod 256, checker pixel is a where row+col is even, else b
const_255 0 255 0 0 49392 252
const_200 0 200 0 0 39200 200
ramp_col4 1 4 0 0 11312 6
ramp_col16 1 16 0 0 23520 24
ramp_row9 1 0 9 0 25144 12
checker_0_255 2 0 255 0 24696 126
ramp_col16_stall 1 16 0 1 23520 24
ramp_row9_stall 1 0 9 1 25144 12
checker_100_40_stall 2 100 40 1 13720 70
const_3_stall 0 3 0 1 0 0

// ==== tb_cnn_top.sv ====
// Image filter testbench
`timescale 1ns/1ps
`include "cnn_macros.svh"

module tb_cnn_top;
    localparam int MAX_CASES     = 16;
    localparam int STALL_TIMEOUT = 5000;

    logic                      clock;
    logic                      reset;
    logic [`CNN_WORD_BITS-1:0] in_data;
    logic                      in_valid;
    logic [`CNN_WORD_BITS-1:0] out_data;
    logic                      out_valid;
    logic                      downstream_stall;
    logic                      stall;

    logic [255:0] case_name [MAX_CASES];
    integer       case_code [MAX_CASES];
    integer       case_a [MAX_CASES];
    integer       case_b [MAX_CASES];
    integer       case_stall [MAX_CASES];
    integer       case_sum [MAX_CASES];
    integer       case_first [MAX_CASES];
    integer       case_count;
    integer       seed;
    logic         out_stall_en;
    bit           abort;

    cnn_top cnn_top_i (
        .clock_i            (clock),
        .reset_i            (reset),
        .in_data_i          (in_data),
        .in_valid_i         (in_valid),
        .out_data_o         (out_data),
        .out_valid_o        (out_valid),
        .downstream_stall_i (downstream_stall),
        .stall_o            (stall)
    );

    cnn_checker cnn_checker_i (
        .clock_i            (clock),
        .out_data_i         (out_data),
        .out_valid_i        (out_valid),
        .downstream_stall_i (downstream_stall),
        .in_valid_i         (in_valid),
        .stall_i            (stall)
    );

    always #5 clock = ~clock;

    // Random sink stall while a stall-mode case drains
    always @(posedge clock) begin
        #1;
        downstream_stall = out_stall_en && (($random(seed) & 3) == 0);
    end

    task automatic read_cases();
        integer fd;
        integer fields;
        logic [8*160-1:0] line;
        case_count = 0;
        fd = $fopen("cnn_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open cnn_cases.txt");
            abort = 1;
        end else begin
            while (!$feof(fd) && case_count < MAX_CASES) begin
                line = '0;
                void'($fgets(line, fd));
                fields = $sscanf(line, "%s %d %d %d %d %d %d", case_name[case_count],
                                 case_code[case_count], case_a[case_count], case_b[case_count],
                                 case_stall[case_count], case_sum[case_count],
                                 case_first[case_count]);
                // Comment lines give fewer fields
                if (fields == 7) case_count = case_count + 1;
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_image(input integer idx);
        integer gaps;
        integer cycles;
        for (int r = 0; r < `CNN_WIDTH && !abort; r++) begin
            for (int c = 0; c < `CNN_WIDTH && !abort; c++) begin
                if (case_stall[idx] != 0) begin
                    gaps = $random(seed) & 3;
                    in_valid = 1'b0;
                    repeat (gaps) begin
                        @(posedge clock);
                        #1;
                    end
                end
                cycles = 0;
                while (stall && !abort) begin
                    in_valid = 1'b0;
                    @(posedge clock);
                    #1;
                    cycles = cycles + 1;
                    if (cycles > STALL_TIMEOUT) begin
                        $display("stall_o stayed high too long in case %0s", case_name[idx]);
                        abort = 1;
                    end
                end
                if (!abort) begin
                    in_data  = cnn_checker_i.pixel_at(case_code[idx], case_a[idx],
                                                      case_b[idx], r, c);
                    in_valid = 1'b1;
                    @(posedge clock);
                    #1;
                    in_valid = 1'b0;
                end
            end
        end
    endtask

    initial begin
        bit timed_out;
        clock            = 1'b0;
        reset            = 1'b1;
        in_data          = '0;
        in_valid         = 1'b0;
        downstream_stall = 1'b0;
        out_stall_en     = 1'b0;
        abort            = 0;
        seed             = 7;
        read_cases();
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        cnn_checker_i.check_idle("reset_state", 20);
        // Images go back to back while the checker drains earlier ones
        fork
            begin
                for (int i = 0; i < case_count && !abort; i++) drive_image(i);
            end
            begin
                for (int i = 0; i < case_count && !abort; i++) begin
                    out_stall_en = (case_stall[i] != 0);
                    cnn_checker_i.check_case(case_name[i], case_code[i], case_a[i], case_b[i],
                                             case_sum[i], case_first[i], timed_out);
                    if (timed_out) abort = 1;
                end
                out_stall_en = 1'b0;
            end
        join
        if (!abort) cnn_checker_i.check_idle("drain", 200);
        $display("summary: %0d cases read, %0d ok, %0d bad, %0d protocol errors", case_count,
                 cnn_checker_i.pass_count, cnn_checker_i.fail_count,
                 cnn_checker_i.protocol_errors);
        if (!abort && case_count > 0 && cnn_checker_i.fail_count == 0 &&
            cnn_checker_i.protocol_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== cnn_checker.sv ====
// Output checker and filter model
`timescale 1ns/1ps
`include "cnn_macros.svh"

module cnn_checker (
    input  logic                      clock_i,
    input  logic [`CNN_WORD_BITS-1:0] out_data_i,
    input  logic                      out_valid_i,
    input  logic                      downstream_stall_i,
    input  logic                      in_valid_i,
    input  logic                      stall_i
);
    localparam int WORD_TIMEOUT = 5000;
    localparam int POOL_W       = `CNN_POOL_WIDTH;
    localparam int WORDS        = POOL_W * POOL_W;

    integer pass_count;
    integer fail_count;
    integer protocol_errors;

    initial begin
        pass_count      = 0;
        fail_count      = 0;
        protocol_errors = 0;
    end

    // Source must hold off while the deserializer is full
    always @(negedge clock_i) begin
        if (in_valid_i && stall_i) begin
            protocol_errors = protocol_errors + 1;
            $display("input strobe was sent while stall_o was high at %0t", $time);
        end
    end

    function automatic integer pixel_at(input integer code, input integer a,
                                        input integer b, input integer r, input integer c);
        integer value;
        case (code)
            0: value = a;
            1: value = (a * c + b * r) % 256;
            default: value = ((r + c) % 2 == 0) ? a : b;
        endcase
        return value & 255;
    endfunction

    // Window wraps from the last column back to column 0
    function automatic integer conv_at(input integer code, input integer a,
                                       input integer b, input integer k, input integer c);
        integer total;
        total = 0;
        for (int rr = 0; rr < `CNN_KERNEL; rr++) begin
            for (int cc = 0; cc < `CNN_KERNEL; cc++) begin
                total = total + ((pixel_at(code, a, b, k + rr, (c + cc) % `CNN_WIDTH)
                        * `CNN_WEIGHT) >> `CNN_Q_SHIFT);
            end
        end
        return total;
    endfunction

    // Last pooled row sees only convolution row 26
    function automatic integer pool_at(input integer code, input integer a,
                                       input integer b, input integer j, input integer i);
        integer best;
        integer value;
        best = 0;
        for (int rr = 0; rr < `CNN_KERNEL; rr++) begin
            if (2 * j + rr < `CNN_WIDTH - 1) begin
                for (int cc = 0; cc < `CNN_KERNEL; cc++) begin
                    value = conv_at(code, a, b, 2 * j + rr, 2 * i + cc);
                    if (value > best) best = value;
                end
            end
        end
        return best;
    endfunction

    task automatic check_case(input logic [255:0] name, input integer code, input integer a,
                              input integer b, input integer exp_sum, input integer exp_first,
                              output bit timed_out);
        integer n;
        integer cycles;
        integer bad;
        integer word_sum;
        integer first_word;
        logic [`CNN_WORD_BITS-1:0] exp_word;
        timed_out  = 0;
        bad        = 0;
        word_sum   = 0;
        first_word = -1;
        for (n = 0; n < WORDS && !timed_out; n++) begin
            cycles = 0;
            @(negedge clock_i);
            while (!(out_valid_i && !downstream_stall_i) && !timed_out) begin
                cycles = cycles + 1;
                if (cycles > WORD_TIMEOUT) timed_out = 1;
                else @(negedge clock_i);
            end
            if (!timed_out) begin
                exp_word = pool_at(code, a, b, n / POOL_W, n % POOL_W);
                if (out_data_i !== exp_word) begin
                    bad = bad + 1;
                    if (bad <= 4)
                        $display("CHECK FAILED %0s word %0d expected 0x%08h actual 0x%08h",
                                 name, n, exp_word, out_data_i);
                end
                word_sum = word_sum + out_data_i[`CNN_PIXEL_BITS-1:0];
                if (n == 0) first_word = out_data_i;
            end
        end
        if (timed_out) begin
            bad = bad + 1;
            $display("%0s: only %0d of %0d words arrived before the timeout", name, n - 1, WORDS);
        end else begin
            if (word_sum != exp_sum) begin
                bad = bad + 1;
                $display("CHECK FAILED %0s sum expected %0d actual %0d", name, exp_sum, word_sum);
            end
            if (first_word != exp_first) begin
                bad = bad + 1;
                $display("CHECK FAILED %0s first word expected %0d actual %0d",
                         name, exp_first, first_word);
            end
        end
        if (bad == 0) pass_count = pass_count + 1;
        else fail_count = fail_count + 1;
        $display("case %0s: %0s, %0d words, %0d errors", name, bad == 0 ? "ok" : "BAD", n, bad);
    endtask

    // Output and input stall must stay quiet for a while
    task automatic check_idle(input logic [127:0] name, input integer cycles);
        integer busy;
        busy = 0;
        repeat (cycles) begin
            @(negedge clock_i);
            if (out_valid_i || stall_i) busy = busy + 1;
        end
        if (busy != 0) begin
            fail_count = fail_count + 1;
            $display("%0s: out_valid_o or stall_o was high in %0d cycles", name, busy);
        end else begin
            pass_count = pass_count + 1;
        end
        $display("case %0s: %0s", name, busy == 0 ? "ok" : "BAD");
    endtask

endmodule

// ==== cnn_top.sv ====
// Streaming convolution and pooling filter
`timescale 1ns/1ps
`include "cnn_macros.svh"

module cnn_top (
    input  logic                      clock_i,
    input  logic                      reset_i,
    input  logic [`CNN_WORD_BITS-1:0] in_data_i,
    input  logic                      in_valid_i,
    output logic [`CNN_WORD_BITS-1:0] out_data_o,
    output logic                      out_valid_o,
    input  logic                      downstream_stall_i,
    output logic                      stall_o
);
    // Input rows
    cnn_pkg::pixel_row_t deser_row;
    logic                deser_row_valid;
    logic                deser_row_last;
    logic                deser_row_accept;

    // Convolution rows
    cnn_pkg::pixel_row_t conv_row;
    logic                conv_row_valid;
    logic                conv_row_last;
    logic                conv_row_accept;

    // Pooled rows
    cnn_pkg::pool_row_t  pool_row;
    logic                pool_row_valid;
    logic                pool_row_accept;

    row_deserializer row_deserializer_i (
        .clock_i      (clock_i),
        .reset_i      (reset_i),
        .in_data_i    (in_data_i),
        .in_valid_i   (in_valid_i),
        .row_o        (deser_row),
        .row_valid_o  (deser_row_valid),
        .row_last_o   (deser_row_last),
        .row_accept_i (deser_row_accept),
        .stall_o      (stall_o)
    );

    conv_row_control conv_row_control_i (
        .clock_i          (clock_i),
        .reset_i          (reset_i),
        .in_row_i         (deser_row),
        .in_row_valid_i   (deser_row_valid),
        .in_row_last_i    (deser_row_last),
        .in_row_accept_o  (deser_row_accept),
        .out_row_o        (conv_row),
        .out_row_valid_o  (conv_row_valid),
        .out_row_last_o   (conv_row_last),
        .out_row_accept_i (conv_row_accept)
    );

    max_pool_row max_pool_row_i (
        .clock_i          (clock_i),
        .reset_i          (reset_i),
        .in_row_i         (conv_row),
        .in_row_valid_i   (conv_row_valid),
        .in_row_last_i    (conv_row_last),
        .in_row_accept_o  (conv_row_accept),
        .out_row_o        (pool_row),
        .out_row_valid_o  (pool_row_valid),
        .out_row_accept_i (pool_row_accept)
    );

    row_serializer row_serializer_i (
        .clock_i            (clock_i),
        .reset_i            (reset_i),
        .row_i              (pool_row),
        .row_valid_i        (pool_row_valid),
        .row_accept_o       (pool_row_accept),
        .out_data_o         (out_data_o),
        .out_valid_o        (out_valid_o),
        .downstream_stall_i (downstream_stall_i)
    );

endmodule

// ==== row_serializer.sv ====
// Pooled row serializer
`timescale 1ns/1ps
`include "cnn_macros.svh"

module row_serializer (
    input  logic                      clock_i,
    input  logic                      reset_i,
    input  cnn_pkg::pool_row_t        row_i,
    input  logic                      row_valid_i,
    output logic                      row_accept_o,
    output logic [`CNN_WORD_BITS-1:0] out_data_o,
    output logic                      out_valid_o,
    input  logic                      downstream_stall_i
);
    localparam int POS_BITS = $clog2(`CNN_POOL_WIDTH);

    cnn_pkg::pool_row_t  row_q;
    logic [POS_BITS-1:0] pos_q;
    logic                busy_q;

    // Only an idle serializer takes a new row
    assign row_accept_o = row_valid_i && !busy_q;

    always_ff @(posedge clock_i) begin
        if (row_accept_o) begin
            row_q <= row_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            pos_q  <= '0;
        end else if (row_accept_o) begin
            busy_q <= 1'b1;
            pos_q  <= '0;
        end else if (busy_q && !downstream_stall_i) begin
            if (pos_q == POS_BITS'(`CNN_POOL_WIDTH - 1)) begin
                busy_q <= 1'b0;
            end
            pos_q <= pos_q + 1'b1;
        end
    end

    // One pixel per word in the low byte
    assign out_data_o  = {{(`CNN_WORD_BITS - `CNN_PIXEL_BITS){1'b0}}, row_q[pos_q]};
    assign out_valid_o = busy_q;

endmodule

// ==== max_pool_row.sv ====
// 2x2 max pooling stage
`timescale 1ns/1ps
`include "cnn_macros.svh"

module max_pool_row (
    input  logic                clock_i,
    input  logic                reset_i,
    input  cnn_pkg::pixel_row_t in_row_i,
    input  logic                in_row_valid_i,
    input  logic                in_row_last_i,
    output logic                in_row_accept_o,
    output cnn_pkg::pool_row_t  out_row_o,
    output logic                out_row_valid_o,
    input  logic                out_row_accept_i
);
    localparam int COL_BITS = $clog2(`CNN_WIDTH);
    localparam int POS_BITS = $clog2(`CNN_POOL_WIDTH);
    localparam int ROW_BITS = $clog2(`CNN_KERNEL + 1);

    cnn_pkg::pool_state_t state_q;
    cnn_pkg::pixel_row_t  in_row_q;
    cnn_pkg::pool_row_t   acc_q;
    logic [POS_BITS-1:0]  pos_q;
    logic [ROW_BITS-1:0]  row_cnt_q;
    logic                 last_q;

    logic [COL_BITS-1:0]  col_base;
    cnn_pkg::pixel_t      pool_max;

    assign in_row_accept_o = (state_q == cnn_pkg::POOL_GET_ROW) && in_row_valid_i;
    assign out_row_valid_o = (state_q == cnn_pkg::POOL_HOLD_ROW);
    assign out_row_o       = acc_q;

    // Unsigned max of the running value and the column pair
    always_comb begin
        col_base = COL_BITS'(pos_q * `CNN_KERNEL);
        pool_max = acc_q[pos_q];
        for (int k = 0; k < `CNN_KERNEL; k++) begin
            if (in_row_q[col_base + k] > pool_max) begin
                pool_max = in_row_q[col_base + k];
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (in_row_accept_o) begin
            in_row_q <= in_row_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q   <= cnn_pkg::POOL_GET_ROW;
            acc_q     <= '0;
            pos_q     <= '0;
            row_cnt_q <= '0;
            last_q    <= 1'b0;
        end else begin
            case (state_q)
                cnn_pkg::POOL_GET_ROW: begin
                    if (in_row_valid_i) begin
                        last_q  <= in_row_last_i;
                        pos_q   <= '0;
                        state_q <= cnn_pkg::POOL_CALC;
                    end
                end
                cnn_pkg::POOL_CALC: begin
                    acc_q[pos_q] <= pool_max;
                    pos_q        <= pos_q + 1'b1;
                    if (pos_q == POS_BITS'(`CNN_POOL_WIDTH - 1)) begin
                        row_cnt_q <= row_cnt_q + 1'b1;
                        // Last convolution row is pooled on its own
                        if (row_cnt_q == ROW_BITS'(`CNN_KERNEL - 1) || last_q) begin
                            state_q <= cnn_pkg::POOL_HOLD_ROW;
                        end else begin
                            state_q <= cnn_pkg::POOL_GET_ROW;
                        end
                    end
                end
                cnn_pkg::POOL_HOLD_ROW: begin
                    if (out_row_accept_i) begin
                        acc_q     <= '0;
                        row_cnt_q <= '0;
                        state_q   <= cnn_pkg::POOL_GET_ROW;
                    end
                end
                default: begin
                    state_q <= cnn_pkg::POOL_GET_ROW;
                end
            endcase
        end
    end

endmodule

// ==== conv_row_control.sv ====
// Convolution row sequencer
`timescale 1ns/1ps
`include "cnn_macros.svh"

module conv_row_control (
    input  logic                clock_i,
    input  logic                reset_i,
    input  cnn_pkg::pixel_row_t in_row_i,
    input  logic                in_row_valid_i,
    input  logic                in_row_last_i,
    output logic                in_row_accept_o,
    output cnn_pkg::pixel_row_t out_row_o,
    output logic                out_row_valid_o,
    output logic                out_row_last_o,
    input  logic                out_row_accept_i
);
    localparam int COL_BITS = $clog2(`CNN_WIDTH);

    cnn_pkg::conv_state_t state_q;
    logic [COL_BITS-1:0]  row_cnt_q;
    logic [COL_BITS-1:0]  col_q;
    logic                 last_q;
    logic                 out_valid_q;
    cnn_pkg::pixel_row_t  out_row_q;

    logic                                               shift_vert;
    logic                                               shift_horiz;
    cnn_pkg::pixel_t [`CNN_KERNEL-1:0][`CNN_KERNEL-1:0] window;
    cnn_pkg::pixel_t                                    mac_sum;

    window_buffer window_buffer_i (
        .clock_i       (clock_i),
        .row_i         (in_row_i),
        .shift_vert_i  (shift_vert),
        .shift_horiz_i (shift_horiz),
        .window_o      (window)
    );

    kernel_mac kernel_mac_i (
        .clock_i  (clock_i),
        .window_i (window),
        .sum_o    (mac_sum)
    );

    // A row is loaded the cycle it is accepted
    assign shift_vert      = (state_q == cnn_pkg::CONV_GET_ROW) && in_row_valid_i;
    assign shift_horiz     = (state_q == cnn_pkg::CONV_CALC);
    assign in_row_accept_o = shift_vert;

    // Sum of the current column is ready in the calc cycle
    always_ff @(posedge clock_i) begin
        if (state_q == cnn_pkg::CONV_CALC) begin
            out_row_q[col_q] <= mac_sum;
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q     <= cnn_pkg::CONV_GET_ROW;
            row_cnt_q   <= '0;
            col_q       <= '0;
            last_q      <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            case (state_q)
                cnn_pkg::CONV_GET_ROW: begin
                    if (in_row_valid_i) begin
                        last_q    <= in_row_last_i;
                        col_q     <= '0;
                        row_cnt_q <= in_row_last_i ? '0 : row_cnt_q + 1'b1;
                        // First row of an image only fills the window
                        if (row_cnt_q != '0) begin
                            state_q <= cnn_pkg::CONV_CALC_WAIT;
                        end
                    end
                end
                cnn_pkg::CONV_CALC_WAIT: begin
                    state_q <= cnn_pkg::CONV_CALC;
                end
                cnn_pkg::CONV_CALC: begin
                    col_q <= col_q + 1'b1;
                    if (col_q == COL_BITS'(`CNN_WIDTH - 1)) begin
                        out_valid_q <= 1'b1;
                        state_q     <= cnn_pkg::CONV_HOLD_ROW;
                    end else begin
                        state_q <= cnn_pkg::CONV_CALC_WAIT;
                    end
                end
                cnn_pkg::CONV_HOLD_ROW: begin
                    if (out_row_accept_i) begin
                        out_valid_q <= 1'b0;
                        state_q     <= cnn_pkg::CONV_GET_ROW;
                    end
                end
                default: begin
                    state_q <= cnn_pkg::CONV_GET_ROW;
                end
            endcase
        end
    end

    assign out_row_o       = out_row_q;
    assign out_row_valid_o = out_valid_q;
    assign out_row_last_o  = last_q;

endmodule

// ==== kernel_mac.sv ====
// Fixed-point 2x2 kernel sum
`timescale 1ns/1ps
`include "cnn_macros.svh"

module kernel_mac (
    input  logic                                               clock_i,
    input  cnn_pkg::pixel_t [`CNN_KERNEL-1:0][`CNN_KERNEL-1:0] window_i,
    output cnn_pkg::pixel_t                                    sum_o
);
    localparam int PROD_BITS = `CNN_PIXEL_BITS + $clog2(`CNN_WEIGHT + 1);
    localparam int ACC_BITS  = PROD_BITS + $clog2(`CNN_KERNEL * `CNN_KERNEL);

    logic [PROD_BITS-1:0] tap_product;
    logic [ACC_BITS-1:0]  tap_sum;

    always_comb begin
        tap_sum     = '0;
        tap_product = '0;
        for (int r = 0; r < `CNN_KERNEL; r++) begin
            for (int c = 0; c < `CNN_KERNEL; c++) begin
                tap_product = PROD_BITS'(`CNN_WEIGHT) * PROD_BITS'(window_i[r][c]);
                // Each term is scaled back before the add
                tap_sum = tap_sum + ACC_BITS'(tap_product >> `CNN_Q_SHIFT);
            end
        end
    end

    // Weights sum to one so the result fits a pixel
    always_ff @(posedge clock_i) begin
        sum_o <= tap_sum[`CNN_PIXEL_BITS-1:0];
    end

endmodule

// ==== window_buffer.sv ====
// Two row window buffer
`timescale 1ns/1ps
`include "cnn_macros.svh"

module window_buffer (
    input  logic                                               clock_i,
    input  cnn_pkg::pixel_row_t                                row_i,
    input  logic                                               shift_vert_i,
    input  logic                                               shift_horiz_i,
    output cnn_pkg::pixel_t [`CNN_KERNEL-1:0][`CNN_KERNEL-1:0] window_o
);
    // Row 0 is the most recent input row
    cnn_pkg::pixel_row_t rows_q [`CNN_KERNEL];

    always_ff @(posedge clock_i) begin
        if (shift_vert_i) begin
            for (int r = 1; r < `CNN_KERNEL; r++) begin
                rows_q[r] <= rows_q[r-1];
            end
            rows_q[0] <= row_i;
        end else if (shift_horiz_i) begin
            // Rotate left so column 0 wraps to the far end
            for (int r = 0; r < `CNN_KERNEL; r++) begin
                rows_q[r] <= {rows_q[r][0], rows_q[r][`CNN_WIDTH-1:1]};
            end
        end
    end

    // Window sits at columns 0 and 1 of both rows
    always_comb begin
        for (int r = 0; r < `CNN_KERNEL; r++) begin
            for (int c = 0; c < `CNN_KERNEL; c++) begin
                window_o[r][c] = rows_q[r][c];
            end
        end
    end

endmodule

// ==== row_deserializer.sv ====
// Pixel stream row deserializer
`timescale 1ns/1ps
`include "cnn_macros.svh"

module row_deserializer (
    input  logic                      clock_i,
    input  logic                      reset_i,
    input  logic [`CNN_WORD_BITS-1:0] in_data_i,
    input  logic                      in_valid_i,
    output cnn_pkg::pixel_row_t       row_o,
    output logic                      row_valid_o,
    output logic                      row_last_o,
    input  logic                      row_accept_i,
    output logic                      stall_o
);
    localparam int COUNT_BITS = $clog2(`CNN_WIDTH);

    cnn_pkg::pixel_row_t   row_q;
    logic [COUNT_BITS-1:0] pix_cnt_q;
    logic [COUNT_BITS-1:0] row_cnt_q;
    logic                  valid_q;
    logic                  last_q;
    logic                  take_pixel;

    // Strobes are only taken while no finished row is waiting
    assign take_pixel = in_valid_i && !valid_q;

    always_ff @(posedge clock_i) begin
        if (take_pixel) begin
            row_q[pix_cnt_q] <= in_data_i[`CNN_PIXEL_BITS-1:0];
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            pix_cnt_q <= '0;
            row_cnt_q <= '0;
            valid_q   <= 1'b0;
            last_q    <= 1'b0;
        end else begin
            if (take_pixel) begin
                if (pix_cnt_q == COUNT_BITS'(`CNN_WIDTH - 1)) begin
                    pix_cnt_q <= '0;
                    valid_q   <= 1'b1;
                    last_q    <= (row_cnt_q == COUNT_BITS'(`CNN_WIDTH - 1));
                end else begin
                    pix_cnt_q <= pix_cnt_q + 1'b1;
                end
            end
            if (valid_q && row_accept_i) begin
                valid_q <= 1'b0;
                // Next image starts from row 0
                row_cnt_q <= last_q ? '0 : row_cnt_q + 1'b1;
            end
        end
    end

    assign row_o       = row_q;
    assign row_valid_o = valid_q;
    assign row_last_o  = last_q;
    assign stall_o     = valid_q;

endmodule

// ==== cnn_pkg.sv ====
// Image filter types
`include "cnn_macros.svh"

package cnn_pkg;

    typedef logic [`CNN_PIXEL_BITS-1:0] pixel_t;
    typedef pixel_t [`CNN_WIDTH-1:0] pixel_row_t;
    typedef pixel_t [`CNN_POOL_WIDTH-1:0] pool_row_t;

    typedef enum logic [1:0] {
        CONV_GET_ROW,
        CONV_CALC_WAIT,
        CONV_CALC,
        CONV_HOLD_ROW
    } conv_state_t;

    typedef enum logic [1:0] {
        POOL_GET_ROW,
        POOL_CALC,
        POOL_HOLD_ROW
    } pool_state_t;

endpackage

// ==== cnn_macros.svh ====
// Image filter constants
`ifndef CNN_MACROS_SVH
`define CNN_MACROS_SVH

// Image geometry
`define CNN_WIDTH       28
`define CNN_KERNEL      2
`define CNN_POOL_WIDTH  14

// Data widths
`define CNN_PIXEL_BITS  8
`define CNN_WORD_BITS   32

// Tap weight in Q6 fixed point
// Four equal taps of 16 add up to one
`define CNN_WEIGHT      16
`define CNN_Q_SHIFT     6

`endif
